//--- logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

    typedef logic [31:0] rv32i_word;  // instruction address or target

    // RV32I major opcodes, only br and jal are acted on
    typedef enum logic [6:0] {
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_other = 7'b0010011
    } rv32i_opcode;

    // table depths, both powers of two so the FIFO heads wrap naturally
    localparam int BTB_DEPTH = 16;
    localparam int BTB_IDX_W = $clog2(BTB_DEPTH);
    localparam int JTB_DEPTH = 8;
    localparam int JTB_IDX_W = $clog2(JTB_DEPTH);

    localparam int HIST_W = 10;  // taken and prediction history width

    localparam logic [HIST_W-1:0] HIST_INIT      = {1'b1, {(HIST_W-1){1'b0}}};
    localparam logic [HIST_W-1:0] TAKE_THRESH    = 10'b1110000000;  // at or above: taken
    localparam logic [HIST_W-1:0] NOTTAKE_THRESH = 10'b0000010000;  // below: not taken
    localparam logic [HIST_W-1:0] FLIP_THRESH    = 10'b1101010000;  // xor band flip point

    localparam rv32i_word NO_TARGET = '1;  // shown when nothing is predicted

endpackage : bp_pkg

`default_nettype wire

//--- logic/resolve_if.sv
`timescale 1ns/1ps
`default_nettype none

interface resolve_if;
    import bp_pkg::*;

    logic        upd;         // one cycle strobe per resolved report
    rv32i_word   pc;          // pc of the resolved instruction
    rv32i_opcode opcode;
    logic        taken;       // actual outcome
    rv32i_word   target;      // actual jump target
    rv32i_word   bimm;        // sign extended B-immediate
    logic        pred_taken;  // prediction the instruction carried

    modport source (
        output upd, pc, opcode, taken, target, bimm, pred_taken
    );

    modport sink (
        input upd, pc, opcode, taken, target, bimm, pred_taken
    );

endinterface : resolve_if

`default_nettype wire

//--- logic/btb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module btb_entry (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc,          // load a new branch into this entry
    input  logic             hist_upd,       // shift outcome into the histories
    input  logic             taken,
    input  logic             pred_taken,
    input  bp_pkg::rv32i_word pc_exe,
    input  bp_pkg::rv32i_word pc_fetch,
    input  bp_pkg::rv32i_word bimm,
    output logic             fetch_hit,
    output logic             exe_hit,
    output logic             predict_taken,
    output bp_pkg::rv32i_word branch_target
);
    import bp_pkg::*;

    logic              valid;
    rv32i_word         tag;
    logic [11:0]       offset;      // bimm[12:1]
    logic [HIST_W-1:0] taken_hist;  // newest outcome at the top
    logic [HIST_W-1:0] pred_hist;
    rv32i_word         offset_sext;

    assign offset_sext   = {{19{offset[11]}}, offset, 1'b0};
    assign branch_target = tag + offset_sext;
    assign fetch_hit     = valid && (pc_fetch == tag);
    assign exe_hit       = valid && (pc_exe == tag);

    // three band rule, the middle band trusts the prediction history
    // unless it has been disagreeing with the outcomes
    always_comb begin
        if (taken_hist >= TAKE_THRESH) begin
            predict_taken = 1'b1;
        end else if (taken_hist < NOTTAKE_THRESH) begin
            predict_taken = 1'b0;
        end else if ((taken_hist ^ pred_hist) >= FLIP_THRESH) begin
            predict_taken = ~pred_hist[HIST_W-1];
        end else begin
            predict_taken = pred_hist[HIST_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag        <= pc_exe;
            offset     <= bimm[12:1];
            taken_hist <= HIST_INIT;
            pred_hist  <= '0;
        end else if (hist_upd) begin
            taken_hist <= {taken, taken_hist[HIST_W-1:1]};
            pred_hist  <= {pred_taken, pred_hist[HIST_W-1:1]};
        end
    end

endmodule : btb_entry

`default_nettype wire

//--- logic/jtb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module jtb_entry (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  bp_pkg::rv32i_word pc_exe,
    input  bp_pkg::rv32i_word pc_fetch,
    input  bp_pkg::rv32i_word jump_target,
    output logic              fetch_hit,
    output logic              exe_hit,
    output bp_pkg::rv32i_word stored_target
);
    import bp_pkg::*;

    logic      valid;
    rv32i_word tag;

    assign fetch_hit = valid && (pc_fetch == tag);
    assign exe_hit   = valid && (pc_exe == tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag           <= pc_exe;
            stored_target <= jump_target;  // jumps need no history
        end
    end

endmodule : jtb_entry

`default_nettype wire

//--- logic/control_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module control_buffer (
    input  logic              clk,
    input  logic              rst,
    resolve_if.sink           rpt,
    input  bp_pkg::rv32i_word fetch_pc,
    output logic              prediction,
    output bp_pkg::rv32i_word target
);
    import bp_pkg::*;

    logic [BTB_DEPTH-1:0] btb_fetch_hits, btb_exe_hits, btb_preds;
    logic [BTB_DEPTH-1:0] btb_alloc, btb_hist_upd;
    rv32i_word            btb_targets [BTB_DEPTH];
    logic [JTB_DEPTH-1:0] jtb_fetch_hits, jtb_exe_hits, jtb_alloc;
    rv32i_word            jtb_targets [JTB_DEPTH];

    logic [BTB_IDX_W-1:0] btb_head, btb_fetch_idx, btb_exe_idx;
    logic [JTB_IDX_W-1:0] jtb_head, jtb_fetch_idx;

    // lowest set bit wins when several entries hold the same pc
    function automatic logic [BTB_IDX_W-1:0] lowest_hit(input logic [BTB_DEPTH-1:0] hits);
        logic [BTB_IDX_W-1:0] idx;
        idx = '0;
        for (int k = BTB_DEPTH - 1; k >= 0; k--) begin
            if (hits[k]) idx = BTB_IDX_W'(k);
        end
        return idx;
    endfunction

    for (genvar i = 0; i < BTB_DEPTH; i++) begin : g_btb
        btb_entry u_entry (
            .clk           (clk),
            .rst           (rst),
            .alloc         (btb_alloc[i]),
            .hist_upd      (btb_hist_upd[i]),
            .taken         (rpt.taken),
            .pred_taken    (rpt.pred_taken),
            .pc_exe        (rpt.pc),
            .pc_fetch      (fetch_pc),
            .bimm          (rpt.bimm),
            .fetch_hit     (btb_fetch_hits[i]),
            .exe_hit       (btb_exe_hits[i]),
            .predict_taken (btb_preds[i]),
            .branch_target (btb_targets[i])
        );
    end

    for (genvar j = 0; j < JTB_DEPTH; j++) begin : g_jtb
        jtb_entry u_entry (
            .clk           (clk),
            .rst           (rst),
            .alloc         (jtb_alloc[j]),
            .pc_exe        (rpt.pc),
            .pc_fetch      (fetch_pc),
            .jump_target   (rpt.target),
            .fetch_hit     (jtb_fetch_hits[j]),
            .exe_hit       (jtb_exe_hits[j]),
            .stored_target (jtb_targets[j])
        );
    end

    assign btb_fetch_idx = lowest_hit(btb_fetch_hits);
    assign btb_exe_idx   = lowest_hit(btb_exe_hits);

    always_comb begin
        jtb_fetch_idx = '0;
        for (int k = JTB_DEPTH - 1; k >= 0; k--) begin
            if (jtb_fetch_hits[k]) jtb_fetch_idx = JTB_IDX_W'(k);
        end
    end

    // one strobe per report at most
    always_comb begin
        btb_alloc    = '0;
        btb_hist_upd = '0;
        jtb_alloc    = '0;
        if (rpt.upd) begin
            case (rpt.opcode)
                op_br: begin
                    if (|btb_exe_hits) btb_hist_upd[btb_exe_idx] = 1'b1;
                    else if (rpt.taken) btb_alloc[btb_head] = 1'b1;
                end
                op_jal: begin
                    if (!(|jtb_exe_hits) && rpt.taken) jtb_alloc[jtb_head] = 1'b1;
                end
                default: ;  // jalr and others are not tracked
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            btb_head <= '0;
            jtb_head <= '0;
        end else begin
            if (|btb_alloc) btb_head <= btb_head + BTB_IDX_W'(1);  // wraps at depth
            if (|jtb_alloc) jtb_head <= jtb_head + JTB_IDX_W'(1);
        end
    end

    // branch table takes precedence over the jump table
    always_comb begin
        prediction = 1'b0;
        target     = NO_TARGET;
        if (|btb_fetch_hits) begin
            prediction = btb_preds[btb_fetch_idx];
            if (btb_preds[btb_fetch_idx]) target = btb_targets[btb_fetch_idx];
        end else if (|jtb_fetch_hits) begin
            prediction = 1'b1;
            target     = jtb_targets[jtb_fetch_idx];
        end
    end

endmodule : control_buffer

`default_nettype wire

//--- logic/exe_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module exe_resolve (
    input  logic                clk,
    input  logic                rst,
    input  logic                report_valid,
    input  logic                report_taken,
    input  logic                report_pred_taken,
    input  bp_pkg::rv32i_opcode report_opcode,
    input  bp_pkg::rv32i_word   report_pc,
    input  bp_pkg::rv32i_word   report_target,
    input  bp_pkg::rv32i_word   report_bimm,
    input  bp_pkg::rv32i_word   report_pred_target,
    resolve_if.source           rpt,
    output logic                mispredict
);
    import bp_pkg::*;

    logic        r_valid;
    rv32i_word   r_pc, r_target, r_pred_target;
    rv32i_opcode r_opcode;
    logic        r_taken, r_pred_taken;
    logic [11:0] r_boff;         // bimm[12:1], bit 0 is always zero
    rv32i_word   bimm_sext;
    rv32i_word   actual_target;
    logic        is_br, is_jal;

    always_ff @(posedge clk) begin
        if (rst) r_valid <= 1'b0;
        else r_valid <= report_valid;
    end

    always_ff @(posedge clk) begin
        if (report_valid) begin
            r_pc          <= report_pc;
            r_opcode      <= report_opcode;
            r_taken       <= report_taken;
            r_target      <= report_target;
            r_boff        <= report_bimm[12:1];
            r_pred_taken  <= report_pred_taken;
            r_pred_target <= report_pred_target;
        end
    end

    assign bimm_sext     = {{19{r_boff[11]}}, r_boff, 1'b0};
    assign is_br         = (r_opcode == op_br);
    assign is_jal        = (r_opcode == op_jal);
    assign actual_target = is_br ? (r_pc + bimm_sext) : r_target;

    assign mispredict = r_valid && ((is_br && (r_taken != r_pred_taken)) ||
                        ((is_br || is_jal) && r_taken && r_pred_taken &&
                         (actual_target != r_pred_target)));

    assign rpt.upd        = r_valid;  // strobe for the table update
    assign rpt.pc         = r_pc;
    assign rpt.opcode     = r_opcode;
    assign rpt.taken      = r_taken;
    assign rpt.target     = r_target;
    assign rpt.bimm       = bimm_sext;
    assign rpt.pred_taken = r_pred_taken;

endmodule : exe_resolve

`default_nettype wire

//--- logic/branch_predictor_top.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_top (
    input  logic                clk,
    input  logic                rst,
    input  bp_pkg::rv32i_word   fetch_pc,
    input  logic                report_valid,
    input  bp_pkg::rv32i_word   report_pc,
    input  bp_pkg::rv32i_opcode report_opcode,
    input  logic                report_taken,
    input  bp_pkg::rv32i_word   report_target,
    input  bp_pkg::rv32i_word   report_bimm,
    input  logic                report_pred_taken,
    input  bp_pkg::rv32i_word   report_pred_target,
    output logic                prediction,
    output bp_pkg::rv32i_word   target,
    output logic                mispredict
);

    resolve_if rpt ();  // registered report, resolve stage to buffer

    exe_resolve u_resolve (
        .clk                (clk),
        .rst                (rst),
        .report_valid       (report_valid),
        .report_taken       (report_taken),
        .report_pred_taken  (report_pred_taken),
        .report_opcode      (report_opcode),
        .report_pc          (report_pc),
        .report_target      (report_target),
        .report_bimm        (report_bimm),
        .report_pred_target (report_pred_target),
        .rpt                (rpt.source),
        .mispredict         (mispredict)
    );

    control_buffer u_cbuf (
        .clk        (clk),
        .rst        (rst),
        .rpt        (rpt.sink),
        .fetch_pc   (fetch_pc),
        .prediction (prediction),
        .target     (target)
    );

endmodule : branch_predictor_top

`default_nettype wire

//--- verif/branch_predictor_sva.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_sva (
    input logic              clk,
    input logic              rst,
    input logic              report_valid,
    input logic              prediction,
    input logic              mispredict,
    input logic              upd,
    input bp_pkg::rv32i_word target
);
    import bp_pkg::*;

    int fail_count = 0;  // failed assertions so far

    // the resolve register adds exactly one cycle
    a_misp_needs_report: assert property (@(posedge clk) disable iff (rst)
        mispredict |-> $past(report_valid))
        else begin
            $error("mispredict high without a report one cycle earlier");
            fail_count++;
        end

    a_no_pred_no_target: assert property (@(posedge clk) disable iff (rst)
        !prediction |-> (target == NO_TARGET))
        else begin
            $error("target is not NO_TARGET while prediction is low");
            fail_count++;
        end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!prediction && !mispredict && !upd))
        else begin
            $error("prediction, mispredict or upd high right after reset");
            fail_count++;
        end

endmodule : branch_predictor_sva

bind branch_predictor_top branch_predictor_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .report_valid (report_valid),
    .prediction   (prediction),
    .mispredict   (mispredict),
    .upd          (rpt.upd),
    .target       (target)
);

`default_nettype wire

//--- verif/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int N_TRAIN     = 12;
    localparam int N_FIFO_BR   = BTB_DEPTH + 4;
    localparam int N_FIFO_J    = JTB_DEPTH + 2;
    localparam int N_RANDOM    = 300;
    localparam int TEST_CYCLES = 4 + 8 + (2 * N_TRAIN + 8) + (3 * N_FIFO_BR + 2 * N_FIFO_J + 2)
                                 + 12 + N_RANDOM + 2;
    localparam int CYCLE_LIMIT = 4 + TEST_CYCLES + 50;  // reset, tests, margin

    logic        clk = 1'b0;
    logic        rst;
    rv32i_word   fetch_pc;
    logic        report_valid;
    rv32i_word   report_pc;
    rv32i_opcode report_opcode;
    logic        report_taken;
    rv32i_word   report_target;
    rv32i_word   report_bimm;
    logic        report_pred_taken;
    rv32i_word   report_pred_target;
    logic        prediction;
    rv32i_word   target;
    logic        mispredict;

    // reference model of both tables
    logic              m_bv [];
    rv32i_word         m_btag [];
    rv32i_word         m_boff [];  // sign extended branch offset
    logic [HIST_W-1:0] m_th [];
    logic [HIST_W-1:0] m_ph [];
    int                m_bhead;
    logic              m_jv [];
    rv32i_word         m_jtag [];
    rv32i_word         m_jtgt [];
    int                m_jhead;

    // model copy of the resolve register
    logic        s_valid;
    rv32i_opcode s_op;
    logic        s_taken;
    logic        s_pt;
    rv32i_word   s_pc;
    rv32i_word   s_target;
    rv32i_word   s_bimm;
    rv32i_word   s_ptarget;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    string       test_name = "reset";
    logic [31:0] rng_state = 32'd95;

    branch_predictor_top uut (
        .clk                (clk),
        .rst                (rst),
        .fetch_pc           (fetch_pc),
        .report_valid       (report_valid),
        .report_pc          (report_pc),
        .report_opcode      (report_opcode),
        .report_taken       (report_taken),
        .report_target      (report_target),
        .report_bimm        (report_bimm),
        .report_pred_taken  (report_pred_taken),
        .report_pred_target (report_pred_target),
        .prediction         (prediction),
        .target             (target),
        .mispredict         (mispredict)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // sign extended B-immediate from bits 12 to 1
    function automatic rv32i_word branch_offset(input rv32i_word imm);
        return {{19{imm[12]}}, imm[12:1], 1'b0};
    endfunction

    function automatic logic band_predict(input logic [HIST_W-1:0] th,
                                          input logic [HIST_W-1:0] ph);
        if (th >= TAKE_THRESH) return 1'b1;
        if (th < NOTTAKE_THRESH) return 1'b0;
        if ((th ^ ph) >= FLIP_THRESH) return !ph[HIST_W-1];
        return ph[HIST_W-1];
    endfunction

    function automatic int btb_lookup(input rv32i_word pc);
        for (int k = 0; k < BTB_DEPTH; k++) begin
            if (m_bv[k] && m_btag[k] == pc) return k;  // lowest index first
        end
        return -1;
    endfunction

    function automatic int jtb_lookup(input rv32i_word pc);
        for (int k = 0; k < JTB_DEPTH; k++) begin
            if (m_jv[k] && m_jtag[k] == pc) return k;
        end
        return -1;
    endfunction

    task automatic clear_model();
        m_bv = new[BTB_DEPTH];
        m_btag = new[BTB_DEPTH];
        m_boff = new[BTB_DEPTH];
        m_th = new[BTB_DEPTH];
        m_ph = new[BTB_DEPTH];
        m_jv = new[JTB_DEPTH];
        m_jtag = new[JTB_DEPTH];
        m_jtgt = new[JTB_DEPTH];
        for (int k = 0; k < BTB_DEPTH; k++) m_bv[k] = 1'b0;
        for (int k = 0; k < JTB_DEPTH; k++) m_jv[k] = 1'b0;
        m_bhead = 0;
        m_jhead = 0;
        s_valid = 1'b0;
        s_op = op_other;
        s_taken = 1'b0;
        s_pt = 1'b0;
        s_pc = '0;
        s_target = '0;
        s_bimm = '0;
        s_ptarget = '0;
    endtask

    // what one rising edge does to the tables and then to the resolve register
    task automatic step_model();
        int idx;
        if (s_valid && s_op == op_br) begin
            idx = btb_lookup(s_pc);
            if (idx >= 0) begin
                m_th[idx] = {s_taken, m_th[idx][HIST_W-1:1]};
                m_ph[idx] = {s_pt, m_ph[idx][HIST_W-1:1]};
            end else if (s_taken) begin
                m_bv[m_bhead] = 1'b1;
                m_btag[m_bhead] = s_pc;
                m_boff[m_bhead] = branch_offset(s_bimm);
                m_th[m_bhead] = HIST_INIT;
                m_ph[m_bhead] = '0;
                m_bhead = (m_bhead + 1) % BTB_DEPTH;
            end
        end else if (s_valid && s_op == op_jal) begin
            if (jtb_lookup(s_pc) < 0 && s_taken) begin
                m_jv[m_jhead] = 1'b1;
                m_jtag[m_jhead] = s_pc;
                m_jtgt[m_jhead] = s_target;
                m_jhead = (m_jhead + 1) % JTB_DEPTH;
            end
        end
        s_valid = report_valid;
        if (report_valid) begin
            s_op = report_opcode;
            s_taken = report_taken;
            s_pt = report_pred_taken;
            s_pc = report_pc;
            s_target = report_target;
            s_bimm = report_bimm;
            s_ptarget = report_pred_target;
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("ERROR %s: %s expected %h, actual %h", test_name, what, exp_v, act_v);
    endtask

    task automatic check_outputs();
        int        bi;
        int        ji;
        logic      exp_pred;
        logic      exp_misp;
        rv32i_word exp_tgt;
        rv32i_word actual;
        bi = btb_lookup(fetch_pc);
        ji = jtb_lookup(fetch_pc);
        exp_pred = 1'b0;
        exp_tgt = NO_TARGET;
        if (bi >= 0) begin
            exp_pred = band_predict(m_th[bi], m_ph[bi]);
            if (exp_pred) exp_tgt = m_btag[bi] + m_boff[bi];
        end else if (ji >= 0) begin
            exp_pred = 1'b1;
            exp_tgt = m_jtgt[ji];
        end
        exp_misp = 1'b0;
        if (s_valid && s_op == op_br && s_taken != s_pt) exp_misp = 1'b1;
        if (s_valid && (s_op == op_br || s_op == op_jal) && s_taken && s_pt) begin
            actual = (s_op == op_br) ? s_pc + branch_offset(s_bimm) : s_target;
            if (actual != s_ptarget) exp_misp = 1'b1;
        end
        checks += 3;
        assert (prediction === exp_pred)
            else report_mismatch("prediction", 32'(exp_pred), 32'(prediction));
        assert (target === exp_tgt)
            else report_mismatch("target", exp_tgt, target);
        assert (mispredict === exp_misp)
            else report_mismatch("mispredict", 32'(exp_misp), 32'(mispredict));
    endtask

    // runs on the falling edge and checks before driving the next inputs
    task automatic drive(input logic valid, input rv32i_opcode op, input rv32i_word pc,
                         input logic taken, input rv32i_word tgt, input rv32i_word imm,
                         input logic pt, input rv32i_word ptgt, input rv32i_word fpc);
        @(negedge clk);
        step_model();
        check_outputs();
        report_valid = valid;
        report_opcode = op;
        report_pc = pc;
        report_taken = taken;
        report_target = tgt;
        report_bimm = imm;
        report_pred_taken = pt;
        report_pred_target = ptgt;
        fetch_pc = fpc;
    endtask

    task automatic idle(input rv32i_word fpc);
        drive(1'b0, op_other, '0, 1'b0, '0, '0, 1'b0, '0, fpc);
    endtask

    task automatic branch(input rv32i_word pc, input rv32i_word imm, input logic taken,
                          input logic pt, input rv32i_word ptgt, input rv32i_word fpc);
        drive(1'b1, op_br, pc, taken, '0, imm, pt, ptgt, fpc);
    endtask

    task automatic jump(input rv32i_word pc, input rv32i_word tgt, input logic pt,
                        input rv32i_word ptgt, input rv32i_word fpc);
        drive(1'b1, op_jal, pc, 1'b1, tgt, '0, pt, ptgt, fpc);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] r2;
        rv32i_opcode op;
        rv32i_word   pc;
        rv32i_word   imm;
        rv32i_word   tgt;
        rv32i_word   ptgt;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = next_random();
            r2 = next_random();
            case (r[9:8])
                2'd0: op = op_br;
                2'd1: op = op_jal;
                2'd2: op = op_jalr;
                default: op = op_other;
            endcase
            pc = 32'h0000_8000 + 4 * ((r >> 16) % 24);  // small pool so entries hit
            imm = branch_offset(r2);
            tgt = {r2[31:2], 2'b00};
            ptgt = (op == op_br) ? pc + imm : tgt;
            if (r[5]) ptgt = ptgt + 32'd4;  // wrong carried target
            drive(r[0] | r[1], op, pc, r[2], tgt, imm, r[3],
                  ptgt, 32'h0000_8000 + 4 * ((r2 >> 20) % 24));
        end
    endtask

    initial begin
        rst = 1'b1;
        fetch_pc = '0;
        report_valid = 1'b0;
        report_pc = '0;
        report_opcode = op_other;
        report_taken = 1'b0;
        report_target = '0;
        report_bimm = '0;
        report_pred_taken = 1'b0;
        report_pred_target = '0;
        clear_model();
        repeat (4) @(negedge clk);
        rst = 1'b0;

        test_name = "after_reset";
        for (int n = 0; n < 4; n++) idle(next_random());

        test_name = "jal_insert";
        jump(32'h0000_0100, 32'h0000_2000, 1'b0, '0, 32'h0000_0100);
        repeat (3) idle(32'h0000_0100);
        jump(32'h0000_0100, 32'h0000_2000, 1'b1, 32'h0000_2000, 32'h0000_0100);  // no realloc
        repeat (3) idle(32'h0000_0100);

        test_name = "branch_train";
        for (int n = 0; n < N_TRAIN; n++) begin
            branch(32'h0000_0400, 32'hFFFF_FFF8, 1'b1, 1'(next_random() >> 31),
                   32'h0000_03F8, 32'h0000_0400);
        end
        for (int n = 0; n < N_TRAIN; n++) begin
            branch(32'h0000_0400, 32'hFFFF_FFF8, 1'b0, 1'(next_random() >> 31),
                   '0, 32'h0000_0400);
        end
        repeat (4) branch(32'h0000_0500, 32'h0000_0FFE, 1'b1, 1'b0, '0, 32'h0000_0500);
        repeat (4) idle(32'h0000_0500);

        test_name = "fifo_order";
        for (int i = 0; i < N_FIFO_BR; i++) begin
            branch(32'h0000_1000 + 4 * i, 32'(16 * (i + 1)), 1'b1, 1'b0, '0, 32'h0000_1000);
        end
        // a not taken outcome against a taken prediction tips resident entries to taken
        for (int i = 0; i < N_FIFO_BR; i++) begin
            branch(32'h0000_1000 + 4 * i, 32'(16 * (i + 1)), 1'b0, 1'b1, '0, 32'h0000_1000);
        end
        for (int i = 0; i < N_FIFO_J; i++) begin
            jump(32'h0000_3000 + 4 * i, 32'h0000_5000 + 64 * i, 1'b0, '0, 32'h0000_3000);
        end
        repeat (2) idle(32'h0000_1000);
        for (int i = 0; i < N_FIFO_BR; i++) idle(32'h0000_1000 + 4 * i);
        for (int i = 0; i < N_FIFO_J; i++) idle(32'h0000_3000 + 4 * i);

        test_name = "mispredict";
        branch(32'h0000_6000, 32'h0000_0040, 1'b1, 1'b0, '0, 32'h0000_6000);
        branch(32'h0000_6000, 32'h0000_0040, 1'b0, 1'b0, '0, 32'h0000_6000);
        branch(32'h0000_6000, 32'h0000_0040, 1'b1, 1'b1, 32'h0000_6040, 32'h0000_6000);
        branch(32'h0000_6000, 32'h0000_0040, 1'b1, 1'b1, 32'h0000_6044, 32'h0000_6000);
        branch(32'h0000_6000, 32'h0000_0040, 1'b0, 1'b1, '0, 32'h0000_6000);
        jump(32'h0000_6100, 32'h0000_7000, 1'b1, 32'h0000_7000, 32'h0000_6100);
        jump(32'h0000_6100, 32'h0000_7000, 1'b1, 32'h0000_7004, 32'h0000_6100);
        jump(32'h0000_6100, 32'h0000_7000, 1'b0, '0, 32'h0000_6100);
        drive(1'b1, op_other, 32'h0000_6000, 1'b1, '0, '0, 1'b0, '0, 32'h0000_6000);
        drive(1'b1, op_jalr, 32'h0000_6100, 1'b1, 32'h0000_7000, '0, 1'b1,
              32'h0000_9000, 32'h0000_6100);
        repeat (2) idle(32'h0000_6000);

        test_name = "random";
        random_traffic();
        repeat (2) idle('0);

        $display("checks %0d, model mismatches %0d, assertion failures %0d",
                 checks, errors, uut.u_sva.fail_count);
        if (errors == 0 && uut.u_sva.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_branch_predictor

`default_nettype wire

//--- vlog.f
logic/bp_pkg.sv
logic/resolve_if.sv
logic/btb_entry.sv
logic/jtb_entry.sv
logic/control_buffer.sv
logic/exe_resolve.sv
logic/branch_predictor_top.sv
verif/branch_predictor_sva.sv
verif/tb_branch_predictor.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_branch_predictor
FILELIST = vlog.f

.PHONY: all lint clean

# build, run, and pass only when the pass message shows up in the output
all:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
